//--- cache/cache_ctrl.sv
`timescale 1ns/1ps
/*
  One request at a time. Lookup reads at cycle 1 and compares at cycle 2.
  After reset all 16 sets are cleared while busy_o is high.
  hit_o keeps the first lookup result through a replay.
*/
module cache_ctrl
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_op_e req_op_i,
  input  cache_addr_u req_addr_i,
  output logic busy_o,
  output logic done_o,
  output logic hit_o,
  input  logic ack_i,
  output logic miss_v_o,
  output cache_op_e miss_op_o,
  output cache_addr_u miss_addr_o,
  output lookup_s lookup_o,
  output stat_entry_s stat_o,
  input  tag_mem_cmd_s miss_tag_cmd_i,
  input  stat_mem_cmd_s miss_stat_cmd_i,
  input  logic miss_active_i,
  input  logic recover_i,
  input  logic miss_done_i
);

  typedef enum logic [2:0] {
    s_clear, s_idle, s_read, s_compare, s_hit_wr, s_miss_req, s_miss_wait, s_done
  } ctrl_state_e;

  ctrl_state_e state_r;
  logic [index_bits_lp-1:0] clear_idx_r;
  logic replay_r, hit_r;
  cache_op_e op_r;
  cache_addr_u addr_r;
  lookup_s lookup_r;
  tag_entry_s [1:0] tag_rd;
  logic [1:0] hit_way;
  logic ld_st, store_op;
  tag_mem_cmd_s own_tag_cmd, tag_cmd;
  stat_mem_cmd_s own_stat_cmd, stat_cmd;

  assign ld_st = op_r inside {op_ld, op_st};
  assign store_op = (op_r == op_st);
  assign hit_way[0] = tag_rd[0].valid & (tag_rd[0].tag == addr_r.access.tag);
  assign hit_way[1] = tag_rd[1].valid & (tag_rd[1].tag == addr_r.access.tag);

  assign busy_o = (state_r != s_idle);
  assign done_o = (state_r == s_hit_wr) | ((state_r == s_done) & (!replay_r | miss_done_i));
  assign hit_o = hit_r;
  assign miss_v_o = (state_r == s_miss_req);
  assign miss_op_o = op_r;
  assign miss_addr_o = addr_r;
  assign lookup_o = lookup_r;

  always_comb begin
    own_tag_cmd = '0;
    own_stat_cmd = '0;
    own_tag_cmd.index = addr_r.access.index;
    own_stat_cmd.index = addr_r.access.index;
    case (state_r)
      s_clear: begin
        own_tag_cmd = '{valid: 1'b1, write: 1'b1, index: clear_idx_r, data: '0, mask: '1};
        own_stat_cmd = '{valid: 1'b1, write: 1'b1, index: clear_idx_r, data: '0, mask: '1};
      end
      s_read: own_tag_cmd.valid = 1'b1;
      s_hit_wr: begin
        own_stat_cmd.valid = 1'b1;
        own_stat_cmd.write = 1'b1;
        own_stat_cmd.data = '{dirty: {2{store_op}}, mru: lookup_r.hit[1]};
        own_stat_cmd.mask = {store_op & lookup_r.hit[1], store_op & lookup_r.hit[0], 1'b1};
      end
      default: ;
    endcase
  end

  assign tag_cmd = miss_active_i ? miss_tag_cmd_i : own_tag_cmd;
  assign stat_cmd = miss_active_i ? miss_stat_cmd_i : own_stat_cmd;

  cache_tag_mem cache_tag_mem_i (.clk_i, .reset_i, .cmd_i(tag_cmd), .data_o(tag_rd));
  cache_stat_mem cache_stat_mem_i (.clk_i, .reset_i, .cmd_i(stat_cmd), .data_o(stat_o));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_clear;
      clear_idx_r <= '0;
      replay_r <= 1'b0;
      hit_r <= 1'b0;
    end else begin
      case (state_r)
        s_clear: begin
          clear_idx_r <= clear_idx_r + 1'b1;
          if (&clear_idx_r) state_r <= s_idle;
        end
        s_idle: if (req_v_i) begin
          state_r <= s_read;
          replay_r <= 1'b0;
        end
        s_read: state_r <= s_compare;
        s_compare: begin
          if (replay_r) state_r <= s_done;
          else if (ld_st && |hit_way) state_r <= s_hit_wr;
          else state_r <= s_miss_req; // flush ops always go to the miss handler
          if (!replay_r) hit_r <= ld_st & (|hit_way);
        end
        s_hit_wr: state_r <= ack_i ? s_idle : s_done;
        s_miss_req: state_r <= s_miss_wait;
        s_miss_wait: if (recover_i) begin
          state_r <= s_read;
          replay_r <= 1'b1;
        end
        s_done: if (ack_i) state_r <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == s_idle && req_v_i) begin
      op_r <= req_op_i;
      addr_r <= req_addr_i;
    end
    if (state_r == s_compare) begin
      lookup_r <= '{tags: tag_rd, hit: hit_way, valid: {tag_rd[1].valid, tag_rd[0].valid}};
    end
  end

endmodule

//--- cache/cache_miss.sv
`timescale 1ns/1ps
/*
  Miss and flush handler. lookup_i must stay unchanged from miss_v_i until done_o.
  Each DMA command level drops for one cycle after a done pulse so that the
  engine can rearm. Address flushes that find no hit change nothing.
*/
module cache_miss
  import cache_pkg::*;
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic miss_v_i,
  input  cache_op_e op_i,
  input  cache_addr_u addr_i,
  input  lookup_s lookup_i,
  input  stat_entry_s stat_i,
  output tag_mem_cmd_s tag_cmd_o,
  output stat_mem_cmd_s stat_cmd_o,
  output logic active_o,
  output logic dma_cmd_v_o,
  output dma_cmd_e dma_cmd_o,
  output logic [addr_width_lp-1:0] dma_addr_o,
  output logic dma_way_o,
  input  logic dma_done_i,
  output logic recover_o,
  output logic done_o,
  input  logic ack_i
);

  typedef enum logic [2:0] {
    s_start,
    s_flush_op,
    s_fill_addr,
    s_evict_addr,
    s_evict_data,
    s_fill_data,
    s_recover,
    s_done
  } miss_state_e;

  miss_state_e state_r, state_n;
  logic chosen_r, chosen_n;
  logic stat_flopped_r, stat_flopped_n;
  logic [1:0] dirty_r, dirty_n;
  logic mru_r, mru_n;
  logic dma_gap_r;
  cache_op_e op_r;
  cache_addr_u addr_r;
  cache_addr_u fill_addr, evict_addr, data_addr;
  logic flush_op, inv_op, flush_hit, store_op;

  assign flush_op = op_r inside {op_tagfl, op_afl, op_aflinv, op_ainv};
  assign inv_op = op_r inside {op_aflinv, op_ainv};
  assign store_op = (op_r == op_st);
  assign flush_hit = (op_r == op_tagfl) | (|lookup_i.hit);
  assign active_o = miss_v_i | !(state_r inside {s_start, s_recover, s_done});
  assign dma_way_o = chosen_n;

  always_comb begin
    fill_addr = '0;
    fill_addr.access.tag = addr_r.access.tag;
    fill_addr.access.index = addr_r.access.index;
    evict_addr = fill_addr;
    evict_addr.access.tag = lookup_i.tags[chosen_r].tag; // old tag of the victim
    data_addr = fill_addr;
    data_addr.access.offset = addr_r.access.offset;
  end

  always_comb begin
    state_n = state_r;
    chosen_n = chosen_r;
    stat_flopped_n = stat_flopped_r;
    dirty_n = dirty_r;
    mru_n = mru_r;
    tag_cmd_o = '0;
    stat_cmd_o = '0;
    tag_cmd_o.index = addr_r.access.index;
    stat_cmd_o.index = addr_r.access.index;
    dma_cmd_v_o = 1'b0;
    dma_cmd_o = dma_fill_addr;
    dma_addr_o = '0;
    recover_o = 1'b0;
    done_o = 1'b0;

    // status read in start returns on the next cycle
    if (state_r inside {s_fill_addr, s_flush_op} && !stat_flopped_r) begin
      dirty_n = stat_i.dirty;
      mru_n = stat_i.mru;
      stat_flopped_n = 1'b1;
    end

    case (state_r)
      s_start: begin
        stat_cmd_o.valid = miss_v_i;
        stat_cmd_o.index = addr_i.access.index;
        stat_flopped_n = 1'b0;
        if (miss_v_i) begin
          state_n = (op_i inside {op_ld, op_st}) ? s_fill_addr : s_flush_op;
        end
      end
      s_fill_addr: begin
        chosen_n = lookup_i.valid[0] ? (lookup_i.valid[1] ? ~mru_n : 1'b1) : 1'b0;
        dma_cmd_v_o = !dma_gap_r;
        dma_cmd_o = dma_fill_addr;
        dma_addr_o = fill_addr;
        tag_cmd_o.valid = dma_done_i;
        tag_cmd_o.write = dma_done_i;
        tag_cmd_o.data[chosen_n] = '{valid: 1'b1, tag: addr_r.access.tag};
        tag_cmd_o.mask[chosen_n] = '1;
        stat_cmd_o.valid = dma_done_i;
        stat_cmd_o.write = dma_done_i;
        stat_cmd_o.data = '{dirty: {2{store_op}}, mru: chosen_n};
        stat_cmd_o.mask = {chosen_n, ~chosen_n, 1'b1};
        if (dma_done_i) begin
          state_n = (dirty_n[chosen_n] & lookup_i.valid[chosen_n]) ? s_evict_addr : s_fill_data;
        end
      end
      s_flush_op: begin
        chosen_n = (op_r == op_tagfl) ? addr_r.flush.way : lookup_i.hit[1];
        tag_cmd_o.valid = flush_hit;
        tag_cmd_o.write = flush_hit;
        tag_cmd_o.data[chosen_n].valid = !inv_op & lookup_i.valid[chosen_n];
        tag_cmd_o.mask[chosen_n].valid = 1'b1;
        stat_cmd_o.valid = flush_hit;
        stat_cmd_o.write = flush_hit;
        stat_cmd_o.data = '{dirty: 2'b00, mru: ~chosen_n};
        stat_cmd_o.mask = {chosen_n, ~chosen_n, 1'b1};
        state_n = (op_r != op_ainv && flush_hit && dirty_n[chosen_n] && lookup_i.valid[chosen_n])
          ? s_evict_addr : s_recover;
      end
      s_evict_addr: begin
        dma_cmd_v_o = !dma_gap_r;
        dma_cmd_o = dma_evict_addr;
        dma_addr_o = evict_addr;
        if (dma_done_i) state_n = s_evict_data;
      end
      s_evict_data: begin
        dma_cmd_v_o = !dma_gap_r;
        dma_cmd_o = dma_evict_data;
        dma_addr_o = evict_addr;
        if (dma_done_i) state_n = flush_op ? s_recover : s_fill_data;
      end
      s_fill_data: begin
        dma_cmd_v_o = !dma_gap_r;
        dma_cmd_o = dma_fill_data;
        dma_addr_o = data_addr;
        if (dma_done_i) state_n = s_recover;
      end
      s_recover: begin
        recover_o = 1'b1;
        state_n = s_done;
      end
      s_done: begin
        done_o = 1'b1;
        if (ack_i) state_n = s_start;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_start;
      chosen_r <= 1'b0;
      stat_flopped_r <= 1'b0;
      dma_gap_r <= 1'b0;
    end else begin
      state_r <= state_n;
      chosen_r <= chosen_n;
      stat_flopped_r <= stat_flopped_n;
      dma_gap_r <= dma_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    dirty_r <= dirty_n;
    mru_r <= mru_n;
    if (state_r == s_start && miss_v_i) begin
      op_r <= op_i;
      addr_r <= addr_i;
    end
  end

endmodule

//--- cache/cache_stat_mem.sv
`timescale 1ns/1ps
/*
  Dirty bits and MRU bit per set, registered read, bit-masked write.
  Mask order follows the entry: dirty[1], dirty[0], mru.
*/
module cache_stat_mem
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  stat_mem_cmd_s cmd_i,
  output stat_entry_s data_o
);

  stat_entry_s mem_r [sets_lp];

  always_ff @(posedge clk_i) begin
    if (cmd_i.valid && cmd_i.write) begin
      mem_r[cmd_i.index] <= (mem_r[cmd_i.index] & ~cmd_i.mask) | (cmd_i.data & cmd_i.mask);
    end
  end

  // read data is kept while writes go on, the miss handler samples it later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_o <= '0;
    end else if (cmd_i.valid && !cmd_i.write) begin
      data_o <= mem_r[cmd_i.index];
    end
  end

endmodule

//--- cache/cache_tag_mem.sv
`timescale 1ns/1ps
/*
  Two tag entries per set, registered read, bit-masked write.
  Read data holds its value while the port is idle or writing.
  Contents are undefined until the controller has swept all sets.
*/
module cache_tag_mem
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  tag_mem_cmd_s cmd_i,
  output tag_entry_s [1:0] data_o
);

  tag_entry_s [1:0] mem_r [sets_lp];

  always_ff @(posedge clk_i) begin
    if (cmd_i.valid && cmd_i.write) begin
      mem_r[cmd_i.index] <= (mem_r[cmd_i.index] & ~cmd_i.mask) | (cmd_i.data & cmd_i.mask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_o <= '0;
    end else if (cmd_i.valid && !cmd_i.write) begin
      data_o <= mem_r[cmd_i.index];
    end
  end

endmodule

//--- common/cache_pkg.sv
/*
  Geometry and shared types of the two-way cache.
  The geometry is fixed here because the address union and the
  memory command structs are built from it.
*/
package cache_pkg;

  localparam int addr_width_lp = 16;
  localparam int block_words_lp = 4;
  localparam int sets_lp = 16;
  localparam int byte_bits_lp = 2;
  localparam int offset_bits_lp = $clog2(block_words_lp);
  localparam int index_bits_lp = $clog2(sets_lp);
  localparam int tag_width_lp = addr_width_lp - byte_bits_lp - offset_bits_lp - index_bits_lp;

  typedef enum logic [2:0] {
    op_ld = 3'd0,
    op_st = 3'd1,
    op_tagfl = 3'd2,
    op_afl = 3'd3,
    op_aflinv = 3'd4,
    op_ainv = 3'd5
  } cache_op_e;

  typedef struct packed {
    logic [tag_width_lp-1:0] tag;
    logic [index_bits_lp-1:0] index;
    logic [offset_bits_lp-1:0] offset;
    logic [byte_bits_lp-1:0] byte_sel;
  } cache_access_s;

  // a tag flush names the way with the lowest tag bit
  typedef struct packed {
    logic [tag_width_lp-2:0] upper;
    logic way;
    logic [index_bits_lp+offset_bits_lp+byte_bits_lp-1:0] rest;
  } cache_flush_s;

  typedef union packed {
    cache_access_s access;
    cache_flush_s flush;
  } cache_addr_u;

  typedef struct packed {
    logic valid;
    logic [tag_width_lp-1:0] tag;
  } tag_entry_s;

  typedef struct packed {
    logic [1:0] dirty; // one per way
    logic mru;
  } stat_entry_s;

  typedef struct packed {
    logic valid;
    logic write;
    logic [index_bits_lp-1:0] index;
    tag_entry_s [1:0] data;
    tag_entry_s [1:0] mask;
  } tag_mem_cmd_s;

  typedef struct packed {
    logic valid;
    logic write;
    logic [index_bits_lp-1:0] index;
    stat_entry_s data;
    logic [2:0] mask;
  } stat_mem_cmd_s;

  typedef struct packed {
    tag_entry_s [1:0] tags;
    logic [1:0] hit;
    logic [1:0] valid;
  } lookup_s;

endpackage

//--- common/dma_pkg.sv
/*
  Commands between the miss handler and the DMA engine, and the
  request seen on the external memory port.
  Address commands take one ack, data commands one ack per word.
*/
package dma_pkg;

  typedef enum logic [1:0] {
    dma_fill_addr = 2'd0,
    dma_evict_addr = 2'd1,
    dma_evict_data = 2'd2,
    dma_fill_data = 2'd3
  } dma_cmd_e;

  typedef struct packed {
    logic valid;
    dma_cmd_e cmd;
    logic [cache_pkg::addr_width_lp-1:0] addr;
    logic way;
  } mem_req_s;

endpackage

//--- compile.f
common/cache_pkg.sv
common/dma_pkg.sv
cache/cache_tag_mem.sv
cache/cache_stat_mem.sv
cache/cache_miss.sv
cache/cache_ctrl.sv
verilog/cache_dma.sv
verilog/cache_miss_top.sv
dv/tb_clock_gen.sv
dv/cache_sva.sv
dv/cache_tb.sv

//--- dv/cache_sva.sv
`timescale 1ns/1ps
/*
  Checks on the link from the miss handler to the DMA engine and on the
  memory port. Bound into cache_miss_top, where both blocks meet.
*/
module cache_sva
  import cache_pkg::*;
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic dma_cmd_v_i,
  input  dma_cmd_e dma_cmd_i,
  input  logic recover_i,
  input  logic done_i,
  input  mem_req_s mem_req_i,
  input  logic mem_ack_i
);

  // one command per level, a new command needs the level to drop first
  one_cmd_per_level: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_i && $past(dma_cmd_v_i) |-> $stable(dma_cmd_i))
    else $error("dma command changed while its level stayed high");

  req_held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i.valid && !mem_ack_i |=> $stable(mem_req_i))
    else $error("memory request changed before it was acknowledged");

  // the replay lookup reads and compares before done_o rises
  recover_then_done: assert property (@(posedge clk_i) disable iff (reset_i)
    recover_i |-> ##3 done_i)
    else $error("done_o did not rise three cycles after recover");

endmodule

bind cache_miss_top cache_sva cache_sva_i (
  .clk_i,
  .reset_i,
  .dma_cmd_v_i(dma_cmd_v),
  .dma_cmd_i(dma_cmd),
  .recover_i(recover),
  .done_i(done_o),
  .mem_req_i(mem_req_o),
  .mem_ack_i
);

//--- dv/cache_tb.sv
`timescale 1ns/1ps
/*
  Runs the tests of dv/cache_vectors.txt, one per line; run from the project root.
  The memory responder acks each beat after a random gap of 0 to 3 cycles.
  Inputs change 2 ns after the rising edge, outputs are sampled there too.
*/
module cache_tb
  import cache_pkg::*;
  import dma_pkg::*;
();

  localparam int words_per_test_lp = 16;
  localparam int max_tests_lp = 32;

  logic clk, reset;
  logic req_v, busy, done, hit, ack, mem_ack;
  cache_op_e req_op;
  cache_addr_u req_addr;
  mem_req_s mem_req;

  logic [15:0] vec [max_tests_lp * words_per_test_lp];
  integer seed;
  int n_tests, cur_test, exp_count, got_count;
  int errors, test_errors, failed_tests;
  bit loaded;
  string test_name;
  dma_cmd_e last_cmd;

  tb_clock_gen tb_clock_gen_i (.clk_o(clk), .reset_o(reset));

  cache_miss_top cache_miss_top_i (
    .clk_i(clk), .reset_i(reset),
    .req_v_i(req_v), .req_op_i(req_op), .req_addr_i(req_addr),
    .busy_o(busy), .done_o(done), .hit_o(hit), .ack_i(ack),
    .mem_req_o(mem_req), .mem_ack_i(mem_ack)
  );

  function automatic string op_name(logic [2:0] op);
    case (op)
      3'd0: return "ld";
      3'd1: return "st";
      3'd2: return "tagfl";
      3'd3: return "afl";
      3'd4: return "aflinv";
      3'd5: return "ainv";
      default: return "bad_op";
    endcase
  endfunction

  function automatic string cmd_name(logic [1:0] cmd);
    case (cmd)
      2'd0: return "fill_addr";
      2'd1: return "evict_addr";
      2'd2: return "evict_data";
      default: return "fill_data";
    endcase
  endfunction

  task automatic note_error();
    test_errors++;
    errors++;
  endtask

  // new requests must arrive in the order the vector lists them
  task automatic log_request();
    int base;
    base = cur_test * words_per_test_lp + 4 + got_count * 3;
    last_cmd = mem_req.cmd;
    if (got_count >= exp_count) begin
      $display("%s: memory request %s 0x%04h came after all %0d expected ones",
               test_name, cmd_name(mem_req.cmd), mem_req.addr, exp_count);
      note_error();
    end else if ({14'b0, mem_req.cmd} != vec[base] || mem_req.addr != vec[base + 1]
                 || {15'b0, mem_req.way} != vec[base + 2]) begin
      $display("ERROR %s request %0d expected %s 0x%04h way %0d actual %s 0x%04h way %0d",
               test_name, got_count + 1, cmd_name(vec[base][1:0]), vec[base + 1],
               vec[base + 2][0], cmd_name(mem_req.cmd), mem_req.addr, mem_req.way);
      note_error();
    end
    got_count++;
  endtask

  task automatic check_beats(int acks);
    int exp_beats;
    exp_beats = (last_cmd inside {dma_evict_data, dma_fill_data}) ? block_words_lp : 1;
    if (acks != exp_beats) begin
      $display("ERROR %s beats of %s expected %0d actual %0d",
               test_name, cmd_name(last_cmd), exp_beats, acks);
      note_error();
    end
  endtask

  initial begin
    int gap;
    int acks;
    logic prev_valid;
    seed = 32'h4177b501;
    gap = 0;
    acks = 0;
    prev_valid = 1'b0;
    mem_ack = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      mem_ack = 1'b0;
      if (mem_req.valid === 1'b1 && !prev_valid) begin
        log_request();
        acks = 0;
        gap = $random(seed) & 3;
      end
      if (mem_req.valid === 1'b0 && prev_valid) check_beats(acks);
      if (mem_req.valid === 1'b1) begin
        if (gap > 0) begin
          gap--;
        end else begin
          mem_ack = 1'b1;
          acks++;
          gap = $random(seed) & 3;
        end
      end
      prev_valid = (mem_req.valid === 1'b1);
    end
  end

  task automatic run_test(int t);
    int base;
    base = t * words_per_test_lp;
    cur_test = t;
    test_name = $sformatf("test%0d_%s", t + 1, op_name(vec[base][2:0]));
    test_errors = 0;
    got_count = 0;
    exp_count = vec[base + 3];
    do begin
      @(posedge clk);
      #2;
    end while (busy !== 1'b0);
    req_v = 1'b1;
    req_op = cache_op_e'(vec[base][2:0]);
    req_addr = vec[base + 1];
    @(posedge clk);
    #2;
    req_v = 1'b0;
    if (busy !== 1'b1) begin
      $display("ERROR %s busy after accept expected 1 actual %0b", test_name, busy);
      note_error();
    end
    while (done !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    if (hit !== vec[base + 2][0]) begin
      $display("ERROR %s hit expected %0d actual %0d", test_name, vec[base + 2][0], hit);
      note_error();
    end
    if (got_count != exp_count) begin
      $display("ERROR %s memory commands expected %0d actual %0d",
               test_name, exp_count, got_count);
      note_error();
    end
    ack = 1'b1;
    @(posedge clk);
    #2;
    ack = 1'b0;
    if (busy !== 1'b0 || done !== 1'b0) begin
      $display("ERROR %s busy and done after ack expected 0 0 actual %0b %0b",
               test_name, busy, done);
      note_error();
    end
    if (test_errors == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d mismatches", test_name, test_errors);
      failed_tests++;
    end
  endtask

  initial begin
    int i;
    req_v = 1'b0;
    req_op = op_ld;
    req_addr = '0;
    ack = 1'b0;
    errors = 0;
    failed_tests = 0;
    n_tests = 0;
    cur_test = 0;
    exp_count = 0;
    got_count = 0;
    loaded = 1'b0;
    for (i = 0; i < max_tests_lp * words_per_test_lp; i++) vec[i] = '1;
    $readmemh("dv/cache_vectors.txt", vec);
    while (n_tests < max_tests_lp && vec[n_tests * words_per_test_lp] != 16'hffff) n_tests++;
    loaded = 1'b1;
    if (n_tests == 0) $display("no tests were read from dv/cache_vectors.txt");
    wait (reset === 1'b0);
    for (i = 0; i < n_tests; i++) run_test(i);
    $display("%0d tests run, %0d failed, %0d errors", n_tests, failed_tests, errors);
    if (errors == 0 && n_tests > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (loaded);
    limit = n_tests * 200 + sets_lp + 4; // clear sweep and reset on top
    repeat (limit) @(posedge clk);
    $display("run timed out after %0d cycles, a test never reached done", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- dv/cache_vectors.txt
// op addr hit ncmd, then four (cmd addr way) triples, all hex, unused triples zero
// op: 0 ld 1 st 2 tagfl 3 afl 4 aflinv 5 ainv; cmd: 0 fill_addr 1 evict_addr 2 evict_data 3 fill_data
0 1110 0 2  0 1110 0  3 1110 0  0 0000 0  0 0000 0
0 1110 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 2210 0 2  0 2210 1  3 2210 1  0 0000 0  0 0000 0
0 3310 0 2  0 3310 0  3 3310 0  0 0000 0  0 0000 0
1 3310 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 2210 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 4410 0 4  0 4410 0  1 3310 0  2 3310 0  3 4410 0 // dirty victim is written back
1 4410 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
3 4410 0 2  1 4410 0  2 4410 0  0 0000 0  0 0000 0
0 4410 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
4 2210 0 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 2210 0 2  0 2210 1  3 2210 1  0 0000 0  0 0000 0
1 2210 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
5 2210 0 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 2210 0 2  0 2210 1  3 2210 1  0 0000 0  0 0000 0
1 4410 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
2 0110 0 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0 // way bit 1 names the clean way
2 0010 0 2  1 4410 0  2 4410 0  0 0000 0  0 0000 0
2 0010 0 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 5520 0 2  0 5520 0  3 5520 0  0 0000 0  0 0000 0
3 7710 0 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
0 4410 1 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
/*
  20 ns clock, reset held high for the first 4 rising edges.
  Reset is released 2 ns after an edge like every other input.
*/
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

//--- verilog/cache_dma.sv
`timescale 1ns/1ps
/*
  Turns a command level into one memory request held until its last ack.
  Address commands end on the first ack, data commands after block_words_lp acks.
  A new command is taken only after the level has been low for a cycle.
*/
module cache_dma
  import cache_pkg::*;
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_v_i,
  input  dma_cmd_e cmd_i,
  input  logic [addr_width_lp-1:0] addr_i,
  input  logic way_i,
  output logic done_o,
  output mem_req_s mem_req_o,
  input  logic mem_ack_i
);

  typedef enum logic [1:0] {s_idle, s_busy, s_hold} dma_state_e;

  dma_state_e state_r;
  mem_req_s req_r;
  logic [offset_bits_lp-1:0] beat_r;
  logic last_beat;

  assign last_beat = (req_r.cmd inside {dma_fill_addr, dma_evict_addr})
    | (beat_r == offset_bits_lp'(block_words_lp - 1));
  assign done_o = (state_r == s_busy) & mem_ack_i & last_beat;
  assign mem_req_o = req_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      req_r.valid <= 1'b0;
      beat_r <= '0;
    end else begin
      case (state_r)
        s_idle: if (cmd_v_i) begin
          req_r <= '{valid: 1'b1, cmd: cmd_i, addr: addr_i, way: way_i};
          beat_r <= '0;
          state_r <= s_busy;
        end
        s_busy: if (mem_ack_i) begin
          beat_r <= beat_r + 1'b1;
          if (last_beat) begin
            req_r.valid <= 1'b0;
            state_r <= s_hold;
          end
        end
        s_hold: if (!cmd_v_i) state_r <= s_idle; // wait for the level to drop
        default: state_r <= s_idle;
      endcase
    end
  end

endmodule

//--- verilog/cache_miss_top.sv
`timescale 1ns/1ps
/*
  Miss-handling subsystem of the two-way cache: controller, miss handler
  and DMA engine. Wait for busy_o low after reset before the first request.
*/
module cache_miss_top
  import cache_pkg::*;
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_op_e req_op_i,
  input  cache_addr_u req_addr_i,
  output logic busy_o,
  output logic done_o,
  output logic hit_o,
  input  logic ack_i,
  output mem_req_s mem_req_o,
  input  logic mem_ack_i
);

  logic miss_v, miss_active, recover, miss_done;
  cache_op_e miss_op;
  cache_addr_u miss_addr;
  lookup_s lookup;
  stat_entry_s stat;
  tag_mem_cmd_s miss_tag_cmd;
  stat_mem_cmd_s miss_stat_cmd;
  logic dma_cmd_v, dma_way, dma_done;
  dma_cmd_e dma_cmd;
  logic [addr_width_lp-1:0] dma_addr;

  cache_ctrl cache_ctrl_i (
    .clk_i, .reset_i, .req_v_i, .req_op_i, .req_addr_i,
    .busy_o, .done_o, .hit_o, .ack_i,
    .miss_v_o(miss_v), .miss_op_o(miss_op), .miss_addr_o(miss_addr),
    .lookup_o(lookup), .stat_o(stat),
    .miss_tag_cmd_i(miss_tag_cmd), .miss_stat_cmd_i(miss_stat_cmd),
    .miss_active_i(miss_active), .recover_i(recover), .miss_done_i(miss_done)
  );

  cache_miss cache_miss_i (
    .clk_i, .reset_i,
    .miss_v_i(miss_v), .op_i(miss_op), .addr_i(miss_addr),
    .lookup_i(lookup), .stat_i(stat),
    .tag_cmd_o(miss_tag_cmd), .stat_cmd_o(miss_stat_cmd), .active_o(miss_active),
    .dma_cmd_v_o(dma_cmd_v), .dma_cmd_o(dma_cmd), .dma_addr_o(dma_addr),
    .dma_way_o(dma_way), .dma_done_i(dma_done),
    .recover_o(recover), .done_o(miss_done), .ack_i
  );

  cache_dma cache_dma_i (
    .clk_i, .reset_i,
    .cmd_v_i(dma_cmd_v), .cmd_i(dma_cmd), .addr_i(dma_addr), .way_i(dma_way),
    .done_o(dma_done), .mem_req_o, .mem_ack_i
  );

endmodule
